//--- design/cache_config.svh
/*
  Geometry of the direct-mapped cache and depth of the burst RAM behind it.
  Included by the package and by RTL that slices addresses into fields.
*/
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// line index bits, 2^8 = 256 lines
`define CACHE_LINE_IX_W 8

// word position within a line, eight 32-bit words per line
`define CACHE_COL_IX_W 3

// byte offset below a 32-bit word
`define CACHE_BYTE_OFS_W 2

// 64-bit beats needed to move one 32 byte line
`define CACHE_BEATS 4

// burst RAM address width in beats, 2^12 x 8 B = 32 KB
`define BR_ADDR_W 12

`endif

//--- design/cache_pkg.sv
/*
  Shared types for the cache: address fields, data widths and the burst FSM states.
  Referenced with scoped names from every design file.
*/
`include "cache_config.svh"

package cache_pkg;

  // requester side data
  typedef logic [31:0] word_t;
  typedef logic [3:0] byte_en_t;

  // one transfer on the burst RAM bus, two words
  typedef logic [63:0] beat_t;

  // address fields, |tag|line|col|byte|
  typedef logic [`CACHE_COL_IX_W-1:0] col_ix_t;
  typedef logic [`CACHE_LINE_IX_W-1:0] line_ix_t;
  typedef logic [31-`CACHE_LINE_IX_W-`CACHE_COL_IX_W-`CACHE_BYTE_OFS_W:0] tag_t;

  typedef logic [$clog2(`CACHE_BEATS)-1:0] beat_ix_t;
  typedef logic [`BR_ADDR_W-1:0] br_addr_t;

  // controller states, eviction always precedes the fill
  typedef enum logic [2:0] {
    st_idle,
    st_evict,
    st_fill_wait,
    st_fill,
    st_done
  } burst_state_t;

endpackage

//--- design/line_xfer_if.sv
/*
  Line transfer channel between the line store and the burst controller.
  Carries miss status, victim beats out and fill beats in.
*/
`timescale 1ns/1ps

interface line_xfer_if;

  // status and victim data from the store
  logic miss;
  logic victim_dirty;
  cache_pkg::tag_t victim_tag;
  cache_pkg::beat_t evict_data;

  // beat selection and fill writes from the controller
  cache_pkg::beat_ix_t beat_ix;
  logic fill_we;
  cache_pkg::beat_t fill_data;
  logic fill_done;

  modport store (
    output miss, victim_dirty, victim_tag, evict_data,
    input beat_ix, fill_we, fill_data, fill_done
  );

  modport ctrl (
    input miss, victim_dirty, victim_tag, evict_data,
    output beat_ix, fill_we, fill_data, fill_done
  );

endinterface

//--- design/cache_line_store.sv
/*
  Tag, valid, dirty and data arrays of the cache with hit detection.
  Serves hits directly and exchanges whole lines with the burst controller.
  After reset the valid bits are cleared one line per cycle.
*/
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_line_store (
  input logic clk,
  input logic rst,
  input cache_pkg::word_t addr,
  input cache_pkg::word_t wdata,
  input cache_pkg::byte_en_t be,
  output cache_pkg::word_t rdata,
  output logic hit,
  line_xfer_if.store xfer
);

  localparam int n_lines = 1 << `CACHE_LINE_IX_W;
  localparam int n_cols = 1 << `CACHE_COL_IX_W;
  localparam int col_lsb = `CACHE_BYTE_OFS_W;
  localparam int line_lsb = col_lsb + `CACHE_COL_IX_W;
  localparam int tag_lsb = line_lsb + `CACHE_LINE_IX_W;

  cache_pkg::col_ix_t col_ix;
  cache_pkg::line_ix_t line_ix;
  cache_pkg::tag_t addr_tag;

  cache_pkg::tag_t tag_mem [n_lines];
  logic valid_mem [n_lines];
  logic dirty_mem [n_lines];
  cache_pkg::word_t [n_cols-1:0] data_mem [n_lines];

  logic walking;
  cache_pkg::line_ix_t walk_ix;
  logic write_hit;

  assign col_ix = addr[col_lsb +: `CACHE_COL_IX_W];
  assign line_ix = addr[line_lsb +: `CACHE_LINE_IX_W];
  assign addr_tag = addr[tag_lsb +: $bits(cache_pkg::tag_t)];

  // no hits until every valid bit has been cleared
  assign hit = !walking && valid_mem[line_ix] && (tag_mem[line_ix] == addr_tag);
  assign write_hit = hit && (be != '0);
  assign rdata = data_mem[line_ix][col_ix];

  assign xfer.miss = !hit && !walking;
  assign xfer.victim_dirty = valid_mem[line_ix] && dirty_mem[line_ix];
  assign xfer.victim_tag = tag_mem[line_ix];
  // low word of a beat sits at the even column
  assign xfer.evict_data = {data_mem[line_ix][{xfer.beat_ix, 1'b1}],
                            data_mem[line_ix][{xfer.beat_ix, 1'b0}]};

  // index walk started by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      walking <= 1'b1;
      walk_ix <= '0;
    end else if (walking) begin
      walk_ix <= walk_ix + 1'b1;
      if (walk_ix == '1) begin
        walking <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (walking) begin
      valid_mem[walk_ix] <= 1'b0;
    end else if (xfer.fill_done) begin
      valid_mem[line_ix] <= 1'b1;
    end
  end

  // a filled line starts clean, a write hit makes it dirty
  always_ff @(posedge clk) begin
    if (xfer.fill_done) begin
      tag_mem[line_ix] <= addr_tag;
      dirty_mem[line_ix] <= 1'b0;
    end else if (write_hit) begin
      dirty_mem[line_ix] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer.fill_we) begin
      data_mem[line_ix][{xfer.beat_ix, 1'b0}] <= xfer.fill_data[31:0];
      data_mem[line_ix][{xfer.beat_ix, 1'b1}] <= xfer.fill_data[63:32];
    end else if (write_hit) begin
      // merge only the enabled bytes
      for (int b = 0; b < $bits(cache_pkg::byte_en_t); b++) begin
        if (be[b]) begin
          data_mem[line_ix][col_ix][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- design/cache_burst_ctrl.sv
/*
  Burst FSM of the cache: writes a dirty victim back as a four-beat burst,
  then fetches the missed line and streams its beats into the line store.
  Commands go out only while the burst RAM is not busy.
*/
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_burst_ctrl (
  input logic clk,
  input logic rst,
  input cache_pkg::word_t addr,
  input cache_pkg::beat_t br_rd_data,
  input logic br_rd_data_ready,
  input logic br_busy,
  output logic br_cmd,
  output logic br_cmd_en,
  output cache_pkg::br_addr_t br_addr,
  output cache_pkg::beat_t br_wr_data,
  line_xfer_if.ctrl xfer
);

  localparam int line_lsb = `CACHE_BYTE_OFS_W + `CACHE_COL_IX_W;
  // byte address to beat address
  localparam int beat_sh = line_lsb - $clog2(`CACHE_BEATS);
  localparam cache_pkg::beat_ix_t last_beat = cache_pkg::beat_ix_t'(`CACHE_BEATS - 1);

  cache_pkg::burst_state_t state;
  cache_pkg::beat_ix_t beat_cnt;

  cache_pkg::line_ix_t line_ix;
  cache_pkg::word_t victim_line_addr;
  cache_pkg::word_t fill_line_addr;
  cache_pkg::br_addr_t victim_br_addr;
  cache_pkg::br_addr_t fill_br_addr;

  assign line_ix = addr[line_lsb +: `CACHE_LINE_IX_W];

  // byte address of the first word of each line, truncated to the RAM size
  assign victim_line_addr = {xfer.victim_tag, line_ix, {line_lsb{1'b0}}};
  assign fill_line_addr = {addr[31:line_lsb], {line_lsb{1'b0}}};
  assign victim_br_addr = victim_line_addr[beat_sh +: `BR_ADDR_W];
  assign fill_br_addr = fill_line_addr[beat_sh +: `BR_ADDR_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cache_pkg::st_idle;
      beat_cnt <= '0;
    end else begin
      case (state)
        cache_pkg::st_idle: begin
          if (xfer.miss) begin
            state <= xfer.victim_dirty ? cache_pkg::st_evict : cache_pkg::st_fill_wait;
          end
        end
        cache_pkg::st_evict: begin
          // beat 0 waits for the RAM, beats 1 to 3 follow back to back
          if (beat_cnt != '0 || !br_busy) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == last_beat) begin
              state <= cache_pkg::st_fill_wait;
            end
          end
        end
        cache_pkg::st_fill_wait: begin
          if (!br_busy) begin
            state <= cache_pkg::st_fill;
          end
        end
        cache_pkg::st_fill: begin
          if (br_rd_data_ready) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == last_beat) begin
              state <= cache_pkg::st_done;
            end
          end
        end
        cache_pkg::st_done: begin
          // line is valid now, requester sees the hit this cycle
          state <= cache_pkg::st_idle;
        end
        default: begin
          state <= cache_pkg::st_idle;
        end
      endcase
    end
  end

  // command issue, the enable is held back while the RAM reports busy
  always_comb begin
    br_cmd = 1'b0;
    br_cmd_en = 1'b0;
    br_addr = fill_br_addr;
    case (state)
      cache_pkg::st_evict: begin
        br_cmd = 1'b1;
        br_addr = victim_br_addr;
        br_cmd_en = (beat_cnt == '0) && !br_busy;
      end
      cache_pkg::st_fill_wait: begin
        br_cmd_en = !br_busy;
      end
      default: begin
        br_cmd_en = 1'b0;
      end
    endcase
  end

  // victim beats come straight from the store, selected by the beat counter
  assign br_wr_data = xfer.evict_data;
  assign xfer.beat_ix = beat_cnt;

  assign xfer.fill_we = (state == cache_pkg::st_fill) && br_rd_data_ready;
  assign xfer.fill_data = br_rd_data;
  assign xfer.fill_done = xfer.fill_we && (beat_cnt == last_beat);

endmodule

//--- design/cache_top.sv
/*
  Top level of the write-back cache between a 32-bit requester and a burst RAM.
  The requester holds its request while busy is high.
*/
`timescale 1ns/1ps

module cache_top (
  input logic clk,
  input logic rst,
  input cache_pkg::word_t addr,
  input cache_pkg::word_t wdata,
  input cache_pkg::byte_en_t be,
  output cache_pkg::word_t rdata,
  output logic rdata_valid,
  output logic busy,
  output logic br_cmd,
  output logic br_cmd_en,
  output cache_pkg::br_addr_t br_addr,
  output cache_pkg::beat_t br_wr_data,
  input cache_pkg::beat_t br_rd_data,
  input logic br_rd_data_ready,
  input logic br_busy
);

  logic hit;

  line_xfer_if xfer ();

  cache_line_store u_store (
    .clk(clk),
    .rst(rst),
    .addr(addr),
    .wdata(wdata),
    .be(be),
    .rdata(rdata),
    .hit(hit),
    .xfer(xfer.store)
  );

  cache_burst_ctrl u_ctrl (
    .clk(clk),
    .rst(rst),
    .addr(addr),
    .br_rd_data(br_rd_data),
    .br_rd_data_ready(br_rd_data_ready),
    .br_busy(br_busy),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data),
    .xfer(xfer.ctrl)
  );

  // zero byte enables mean a read
  assign busy = !hit;
  assign rdata_valid = hit && (be == '0);

endmodule

//--- sim/tb_clock_gen.sv
/*
  Clock and reset source for the cache testbench.
  20 ns clock, reset held for eight rising edges and released on a falling edge.
*/
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period = 10,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst
);

  always #half_period clk = ~clk;

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    // release away from the sampling edge
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- sim/burst_ram_model.sv
/*
  Behavioral burst RAM for the cache testbench.
  Accepts one command at a time, returns read bursts after a random latency
  and raises busy at random while idle. Preloaded from the beat address.
*/
`timescale 1ns/1ps
`include "cache_config.svh"

module burst_ram_model (
  input logic clk,
  input logic rst,
  input logic br_cmd,
  input logic br_cmd_en,
  input cache_pkg::br_addr_t br_addr,
  input cache_pkg::beat_t br_wr_data,
  output cache_pkg::beat_t br_rd_data,
  output logic br_rd_data_ready,
  output logic br_busy
);

  localparam int depth = 1 << `BR_ADDR_W;

  cache_pkg::beat_t mem [depth];
  logic [31:0] rand_state;
  int wr_left;
  int rd_wait;
  int rd_left;
  cache_pkg::br_addr_t wr_ptr;
  cache_pkg::br_addr_t rd_ptr;

  function automatic logic [31:0] next_rand(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // each word holds its own word address xored with a marker
  initial begin
    br_busy = 1'b0;
    br_rd_data_ready = 1'b0;
    br_rd_data = '0;
    for (int a = 0; a < depth; a++) begin
      mem[a] = {32'(2 * a + 1) ^ 32'h5a5a0000, 32'(2 * a) ^ 32'h5a5a0000};
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      rand_state = 32'h080f79e1;
      wr_left = 0;
      rd_wait = 0;
      rd_left = 0;
      br_busy <= 1'b0;
      br_rd_data_ready <= 1'b0;
      br_rd_data <= '0;
    end else begin
      rand_state = next_rand(rand_state);
      br_rd_data_ready <= 1'b0;
      if (wr_left > 0) begin
        // beats 1 to 3 follow the command back to back
        mem[wr_ptr] = br_wr_data;
        wr_ptr++;
        wr_left--;
      end else if (rd_wait > 0) begin
        rd_wait--;
      end else if (rd_left > 0) begin
        br_rd_data <= mem[rd_ptr];
        br_rd_data_ready <= 1'b1;
        rd_ptr++;
        rd_left--;
      end else if (br_cmd_en) begin
        if (br_cmd) begin
          mem[br_addr] = br_wr_data;
          wr_ptr = br_addr;
          wr_ptr++;
          wr_left = `CACHE_BEATS - 1;
        end else begin
          // first beat is seen 2 to 9 cycles after the command
          rd_ptr = br_addr;
          rd_wait = int'(rand_state[30:28]);
          rd_left = `CACHE_BEATS;
        end
      end
      br_busy <= (wr_left > 0) || (rd_wait > 0) || (rd_left > 0) ||
                 (rand_state[25:24] == 2'b11);
    end
  end

endmodule

//--- sim/cache_asserts.sv
/*
  Protocol assertions on the burst RAM port and the requester handshake.
  Bound into every instance of the cache top level.
*/
`timescale 1ns/1ps

module cache_asserts (
  input logic clk,
  input logic rst,
  input logic br_cmd_en,
  input logic br_busy,
  input logic busy,
  input logic rdata_valid
);

  // a command is a single-cycle pulse
  cmd_single_cycle: assert property (@(posedge clk) disable iff (rst)
    br_cmd_en |=> !br_cmd_en)
    else $error("br_cmd_en was high for two cycles in a row");

  cmd_only_when_ready: assert property (@(posedge clk) disable iff (rst)
    br_cmd_en |-> !br_busy)
    else $error("br_cmd_en was raised while br_busy was high");

  valid_only_when_done: assert property (@(posedge clk) disable iff (rst)
    rdata_valid |-> !busy)
    else $error("rdata_valid was high while busy was high");

endmodule

bind cache_top cache_asserts asserts0 (
  .clk(clk),
  .rst(rst),
  .br_cmd_en(br_cmd_en),
  .br_busy(br_busy),
  .busy(busy),
  .rdata_valid(rdata_valid)
);

//--- sim/cache_tb.sv
/*
  Top of the cache testbench. Applies a table of directed and random requests,
  predicts every read from a shadow memory and reports the error counts.
*/
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb;

  localparam int n_directed = 10;
  localparam int n_random = 48;
  localparam int n_ops = n_directed + n_random;
  localparam int timeout_cycles = 8 + 40 * n_ops;
  localparam int shadow_words = 1 << (`BR_ADDR_W + 1);

  // expected path through the cache
  localparam logic [1:0] any_path = 2'd0;
  localparam logic [1:0] want_hit = 2'd1;
  localparam logic [1:0] want_miss = 2'd2;

  typedef struct {
    logic wr;
    cache_pkg::word_t addr;
    cache_pkg::word_t data;
    cache_pkg::byte_en_t be;
    logic [1:0] path;
  } op_t;

  logic clk;
  logic rst;
  cache_pkg::word_t addr;
  cache_pkg::word_t wdata;
  cache_pkg::byte_en_t be;
  cache_pkg::word_t rdata;
  logic rdata_valid;
  logic busy;
  logic br_cmd;
  logic br_cmd_en;
  cache_pkg::br_addr_t br_addr;
  cache_pkg::beat_t br_wr_data;
  cache_pkg::beat_t br_rd_data;
  logic br_rd_data_ready;
  logic br_busy;

  op_t op_table [n_ops];
  cache_pkg::word_t shadow [shadow_words];
  logic [31:0] rand_state;
  int data_errors;
  int timing_errors;
  int cycles;

  tb_clock_gen clock0 (.clk(clk), .rst(rst));

  cache_top dut0 (
    .clk(clk),
    .rst(rst),
    .addr(addr),
    .wdata(wdata),
    .be(be),
    .rdata(rdata),
    .rdata_valid(rdata_valid),
    .busy(busy),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data),
    .br_rd_data(br_rd_data),
    .br_rd_data_ready(br_rd_data_ready),
    .br_busy(br_busy)
  );

  burst_ram_model ram0 (
    .clk(clk),
    .rst(rst),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data),
    .br_rd_data(br_rd_data),
    .br_rd_data_ready(br_rd_data_ready),
    .br_busy(br_busy)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_word,
                                                   input cache_pkg::word_t new_word,
                                                   input cache_pkg::byte_en_t en);
    cache_pkg::word_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (en[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  task automatic set_op(input int n, input logic wr, input cache_pkg::word_t a,
                        input cache_pkg::word_t d, input cache_pkg::byte_en_t en,
                        input logic [1:0] path);
    op_table[n].wr = wr;
    op_table[n].addr = a;
    op_table[n].data = d;
    op_table[n].be = en;
    op_table[n].path = path;
  endtask

  // called on a falling edge, returns on the falling edge after completion
  task automatic run_op(input int n, input op_t op);
    logic [`BR_ADDR_W:0] idx;
    logic first;
    idx = op.addr[`BR_ADDR_W+2:2];
    first = 1'b1;
    addr = op.addr;
    wdata = op.data;
    be = op.wr ? op.be : 4'h0;
    #5;
    while (busy) begin
      if (first && op.path == want_hit) begin
        $display("mismatch busy at op %0d: got %h expected %h", n, busy, 1'b0);
        timing_errors++;
      end
      first = 1'b0;
      @(negedge clk);
      #5;
    end
    if (first && op.path == want_miss) begin
      $display("mismatch busy at op %0d: got %h expected %h", n, busy, 1'b1);
      timing_errors++;
    end
    if (op.wr) begin
      if (rdata_valid !== 1'b0) begin
        $display("mismatch rdata_valid at op %0d: got %h expected %h", n, rdata_valid, 1'b0);
        timing_errors++;
      end
      shadow[idx] = merge_bytes(shadow[idx], op.data, op.be);
    end else begin
      if (rdata_valid !== 1'b1) begin
        $display("mismatch rdata_valid at op %0d: got %h expected %h", n, rdata_valid, 1'b1);
        timing_errors++;
      end
      if (rdata !== shadow[idx]) begin
        $display("mismatch rdata at op %0d addr %h: got %h expected %h",
                 n, op.addr, rdata, shadow[idx]);
        data_errors++;
      end
    end
    @(negedge clk);
  endtask

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the operation table did not finish in %0d cycles", timeout_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    addr = '0;
    wdata = '0;
    be = '0;
    data_errors = 0;
    timing_errors = 0;
    for (int i = 0; i < shadow_words; i++) begin
      shadow[i] = 32'(i) ^ 32'h5a5a0000;
    end

    // line 8 with tags 0, 1 and 2
    set_op(0, 1'b0, 32'h0000_0100, 32'h0, 4'h0, want_miss);
    set_op(1, 1'b0, 32'h0000_0114, 32'h0, 4'h0, want_hit);
    set_op(2, 1'b1, 32'h0000_0108, 32'hdead_beef, 4'b0101, want_hit);
    set_op(3, 1'b0, 32'h0000_0108, 32'h0, 4'h0, want_hit);
    set_op(4, 1'b0, 32'h0000_2108, 32'h0, 4'h0, want_miss);
    set_op(5, 1'b0, 32'h0000_0108, 32'h0, 4'h0, want_miss);
    set_op(6, 1'b1, 32'h0000_0104, 32'h1234_5678, 4'b1100, want_hit);
    set_op(7, 1'b1, 32'h0000_4104, 32'hcafe_f00d, 4'b0011, want_miss);
    set_op(8, 1'b0, 32'h0000_4104, 32'h0, 4'h0, want_hit);
    set_op(9, 1'b0, 32'h0000_0104, 32'h0, 4'h0, want_miss);

    // random traffic over four tags and eight lines for many conflicts
    rand_state = 32'h080f79e1;
    for (int i = n_directed; i < n_ops; i++) begin
      cache_pkg::word_t a;
      cache_pkg::byte_en_t en;
      logic wr;
      rand_state = lcg_step(rand_state);
      a = {17'd0, rand_state[31:30], 5'd0, rand_state[29:27], rand_state[26:24], 2'b00};
      wr = rand_state[23];
      en = rand_state[22:19];
      if (wr && en == 4'h0) begin
        en = 4'hf;
      end
      rand_state = lcg_step(rand_state);
      set_op(i, wr, a, rand_state, wr ? en : 4'h0, any_path);
    end

    @(negedge clk);
    while (rst) begin
      @(negedge clk);
    end
    for (int i = 0; i < n_ops; i++) begin
      run_op(i, op_table[i]);
    end

    $display("errors: %0d data, %0d timing, %0d total",
             data_errors, timing_errors, data_errors + timing_errors);
    if (data_errors == 0 && timing_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+design
design/cache_pkg.sv
design/line_xfer_if.sv
design/cache_line_store.sv
design/cache_burst_ctrl.sv
design/cache_top.sv
sim/tb_clock_gen.sv
sim/burst_ram_model.sv
sim/cache_asserts.sv
sim/cache_tb.sv

//--- Makefile
TOP := cache_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

obj_dir/V$(TOP): verilog.f $(wildcard design/*.sv design/*.svh sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
